//--- build.f
verilog/operand_fetch_pkg.sv
verilog/sram_2r1w.sv
verilog/scalar_register_file.sv
verilog/vector_register_file.sv
verilog/operand_select.sv
verilog/operand_fetch_stage.sv
sim/operand_fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the operand fetch testbench with Verilator and runs it once.
# The run counts as passed only if the pass message shows up in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module operand_fetch_tb \
	-f build.f \
	-o operand_fetch_sim

out=$(./obj_dir/operand_fetch_sim)
echo "$out"

if echo "$out" | grep -q "^Simulation passed$"; then
	exit 0
else
	exit 1
fi

//--- sim/operand_fetch_cases.txt
# W thread reg is_vector mask value
# I thread hs1 hs2 hv1 hv2 s1 s2 v1 v2 op1 op2 msrc svec pc imm | valid chk op1 op2 mask store
# R thread arms a rollback for the next record, N is an idle cycle, chk bits 0..3 = op1 op2 mask store
W 0 01 0 0 00000000000000000000000000000012
W 0 02 0 0 0000000000000000000000000000000b
W 0 03 1 f 44444444333333332222222211111111
W 0 04 1 f 88888888777777776666666655555555
W 0 04 1 5 ddddddddccccccccbbbbbbbbaaaaaaaa
W 1 01 0 0 00000000000000000000000000000037
W 2 01 0 0 00000000000000000000000000000049
N
I 0 0 0 1 0 00 00 03 00 1 3 2 0 00000200 00000007 1 7 44444444333333332222222211111111 00000007000000070000000700000007 f 0
I 0 0 0 1 0 00 00 04 00 1 3 2 0 00000204 00000007 1 1 88888888cccccccc66666666aaaaaaaa 0 0 0
I 0 1 1 0 0 01 02 00 00 2 0 0 0 00000100 00000000 1 7 00000104000001040000010400000104 0000000b0000000b0000000b0000000b 2 0
I 0 0 1 0 0 00 02 00 00 0 3 1 0 00000108 00000000 1 c 0 0 b 0000000000000000000000000000000b
I 0 0 0 0 1 00 00 00 03 0 1 2 1 0000010c 00000000 1 a 0 44444444333333332222222211111111 0 44444444333333332222222211111111
I 1 1 0 0 0 01 00 00 00 0 3 2 0 00000300 00000000 1 1 00000037000000370000003700000037 0 0 0
I 2 1 0 0 0 01 00 00 00 0 3 2 0 00000400 00000000 1 1 00000049000000490000004900000049 0 0 0
I 0 1 0 0 0 01 00 00 00 0 3 2 0 00000110 00000000 1 1 00000012000000120000001200000012 0 0 0
I 1 1 0 0 0 01 00 00 00 0 3 2 0 00000304 00000000 0 0 0 0 0 0
R 1
I 0 1 0 0 0 01 00 00 00 0 3 2 0 00000114 00000000 1 1 00000012000000120000001200000012 0 0 0
R 2
I 2 1 0 0 0 01 00 00 00 0 3 2 0 00000404 00000000 0 0 0 0 0 0
R 0
I 3 0 0 0 0 00 00 00 00 2 3 2 0 00000500 00000009 1 3 00000504000005040000050400000504 00000009000000090000000900000009 0 0
N
N

//--- sim/operand_fetch_tb.sv
// Testbench for the operand fetch stage. It loads writeback, issue and
// rollback records from the cases file, plays one record per clock cycle
// and compares each issue's outputs two cycles later.

`timescale 1ns/1ps
`default_nettype none

module operand_fetch_tb;

	localparam int MAX_RECORDS = 64;

	logic clk;
	logic reset;
	logic ts_instruction_valid;
	operand_fetch_pkg::thread_idx_t ts_thread_idx;
	operand_fetch_pkg::subcycle_t ts_subcycle;
	logic ts_has_scalar1;
	logic ts_has_scalar2;
	logic ts_has_vector1;
	logic ts_has_vector2;
	operand_fetch_pkg::register_idx_t ts_scalar_sel1;
	operand_fetch_pkg::register_idx_t ts_scalar_sel2;
	operand_fetch_pkg::register_idx_t ts_vector_sel1;
	operand_fetch_pkg::register_idx_t ts_vector_sel2;
	operand_fetch_pkg::op1_src_t ts_op1_src;
	operand_fetch_pkg::op2_src_t ts_op2_src;
	operand_fetch_pkg::mask_src_t ts_mask_src;
	logic ts_store_value_is_vector;
	operand_fetch_pkg::scalar_t ts_pc;
	operand_fetch_pkg::scalar_t ts_immediate_value;
	logic wb_rollback_en;
	operand_fetch_pkg::thread_idx_t wb_rollback_thread_idx;
	logic wb_writeback_en;
	operand_fetch_pkg::thread_idx_t wb_writeback_thread_idx;
	operand_fetch_pkg::register_idx_t wb_writeback_reg;
	logic wb_writeback_is_vector;
	operand_fetch_pkg::vector_t wb_writeback_value;
	operand_fetch_pkg::lane_mask_t wb_writeback_mask;
	logic of_instruction_valid;
	operand_fetch_pkg::thread_idx_t of_thread_idx;
	operand_fetch_pkg::subcycle_t of_subcycle;
	operand_fetch_pkg::vector_t of_operand1;
	operand_fetch_pkg::vector_t of_operand2;
	operand_fetch_pkg::lane_mask_t of_mask_value;
	operand_fetch_pkg::vector_t of_store_value;
	operand_fetch_pkg::scalar_t of_immediate_value;
	operand_fetch_pkg::scalar_t of_pc;

	// One entry per record; W records keep reg in rec_s1, is_vector in
	// rec_svec, mask in rec_mask_exp and the value in rec_op1_exp
	byte rec_kind[MAX_RECORDS];
	operand_fetch_pkg::thread_idx_t rec_thread[MAX_RECORDS];
	logic rec_hs1[MAX_RECORDS];
	logic rec_hs2[MAX_RECORDS];
	logic rec_hv1[MAX_RECORDS];
	logic rec_hv2[MAX_RECORDS];
	operand_fetch_pkg::register_idx_t rec_s1[MAX_RECORDS];
	operand_fetch_pkg::register_idx_t rec_s2[MAX_RECORDS];
	operand_fetch_pkg::register_idx_t rec_v1[MAX_RECORDS];
	operand_fetch_pkg::register_idx_t rec_v2[MAX_RECORDS];
	operand_fetch_pkg::op1_src_t rec_op1[MAX_RECORDS];
	operand_fetch_pkg::op2_src_t rec_op2[MAX_RECORDS];
	operand_fetch_pkg::mask_src_t rec_msrc[MAX_RECORDS];
	logic rec_svec[MAX_RECORDS];
	operand_fetch_pkg::scalar_t rec_pc[MAX_RECORDS];
	operand_fetch_pkg::scalar_t rec_imm[MAX_RECORDS];
	logic rec_ev[MAX_RECORDS];
	logic [3:0] rec_chk[MAX_RECORDS];
	operand_fetch_pkg::vector_t rec_op1_exp[MAX_RECORDS];
	operand_fetch_pkg::vector_t rec_op2_exp[MAX_RECORDS];
	operand_fetch_pkg::lane_mask_t rec_mask_exp[MAX_RECORDS];
	operand_fetch_pkg::vector_t rec_store_exp[MAX_RECORDS];
	logic rec_rb_en[MAX_RECORDS];
	operand_fetch_pkg::thread_idx_t rec_rb_thread[MAX_RECORDS];

	int num_records;
	int cycle_limit;
	int cycle_count;
	int step;
	int errors;
	int tests;
	int due_q[$];
	int index_q[$];
	logic loaded;

	operand_fetch_stage dut_i (.*);

	always #5 clk = ~clk;

	// Watchdog sized from the number of records
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout after %0d cycles", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic load_cases(output logic ok);
		int fd;
		int code;
		byte kind;
		string rest;
		logic rb_armed;
		operand_fetch_pkg::thread_idx_t rb_thread;
		ok = 1'b1;
		rb_armed = 1'b0;
		rb_thread = '0;
		num_records = 0;
		fd = $fopen("sim/operand_fetch_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the cases file");
			ok = 1'b0;
		end
		while (fd != 0 && !$feof(fd) && num_records < MAX_RECORDS)
		begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1)
				break;
			if (kind == "#")
			begin
				code = $fgets(rest, fd);
				continue;
			end
			// A rollback only arms the strobe for the record that follows
			if (kind == "R")
			begin
				code = $fscanf(fd, "%h", rb_thread);
				if (code != 1)
				begin
					$display("Rollback record without a thread in the cases file");
					ok = 1'b0;
				end
				rb_armed = 1'b1;
				continue;
			end
			rec_kind[num_records] = kind;
			rec_ev[num_records] = 1'b0;
			rec_chk[num_records] = 4'h0;
			code = 0;
			if (kind == "W")
				code = $fscanf(fd, "%h %h %h %h %h", rec_thread[num_records],
					rec_s1[num_records], rec_svec[num_records],
					rec_mask_exp[num_records], rec_op1_exp[num_records]);
			else if (kind == "I")
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					rec_thread[num_records], rec_hs1[num_records], rec_hs2[num_records],
					rec_hv1[num_records], rec_hv2[num_records], rec_s1[num_records],
					rec_s2[num_records], rec_v1[num_records], rec_v2[num_records],
					rec_op1[num_records], rec_op2[num_records], rec_msrc[num_records],
					rec_svec[num_records], rec_pc[num_records], rec_imm[num_records],
					rec_ev[num_records], rec_chk[num_records], rec_op1_exp[num_records],
					rec_op2_exp[num_records], rec_mask_exp[num_records],
					rec_store_exp[num_records]);
			// A short or unknown record would otherwise play as garbage
			if ((kind == "W" && code != 5) || (kind == "I" && code != 21)
				|| (kind != "W" && kind != "I" && kind != "N"))
			begin
				$display("Malformed record %0d in the cases file", num_records);
				ok = 1'b0;
			end
			rec_rb_en[num_records] = rb_armed;
			rec_rb_thread[num_records] = rb_thread;
			rb_armed = 1'b0;
			num_records++;
		end
		if (fd != 0)
			$fclose(fd);
	endtask

	// Every input goes back to an idle value before a record is applied
	task automatic drive_idle;
		ts_instruction_valid = 1'b0;
		ts_thread_idx = '0;
		ts_subcycle = '0;
		ts_has_scalar1 = 1'b0;
		ts_has_scalar2 = 1'b0;
		ts_has_vector1 = 1'b0;
		ts_has_vector2 = 1'b0;
		ts_scalar_sel1 = '0;
		ts_scalar_sel2 = '0;
		ts_vector_sel1 = '0;
		ts_vector_sel2 = '0;
		ts_op1_src = '0;
		ts_op2_src = '0;
		ts_mask_src = '0;
		ts_store_value_is_vector = 1'b0;
		ts_pc = '0;
		ts_immediate_value = '0;
		wb_rollback_en = 1'b0;
		wb_rollback_thread_idx = '0;
		wb_writeback_en = 1'b0;
		wb_writeback_thread_idx = '0;
		wb_writeback_reg = '0;
		wb_writeback_is_vector = 1'b0;
		wb_writeback_value = '0;
		wb_writeback_mask = '0;
	endtask

	task automatic apply_record(input int i);
		drive_idle();
		wb_rollback_en = rec_rb_en[i];
		wb_rollback_thread_idx = rec_rb_thread[i];
		if (rec_kind[i] == "W")
		begin
			wb_writeback_en = 1'b1;
			wb_writeback_thread_idx = rec_thread[i];
			wb_writeback_reg = rec_s1[i];
			wb_writeback_is_vector = rec_svec[i];
			wb_writeback_mask = rec_mask_exp[i];
			wb_writeback_value = rec_op1_exp[i];
		end
		else if (rec_kind[i] == "I")
		begin
			ts_instruction_valid = 1'b1;
			ts_thread_idx = rec_thread[i];
			ts_subcycle = operand_fetch_pkg::subcycle_t'(i);
			ts_has_scalar1 = rec_hs1[i];
			ts_has_scalar2 = rec_hs2[i];
			ts_has_vector1 = rec_hv1[i];
			ts_has_vector2 = rec_hv2[i];
			ts_scalar_sel1 = rec_s1[i];
			ts_scalar_sel2 = rec_s2[i];
			ts_vector_sel1 = rec_v1[i];
			ts_vector_sel2 = rec_v2[i];
			ts_op1_src = rec_op1[i];
			ts_op2_src = rec_op2[i];
			ts_mask_src = rec_msrc[i];
			ts_store_value_is_vector = rec_svec[i];
			ts_pc = rec_pc[i];
			ts_immediate_value = rec_imm[i];
		end
		// The result of this record is due two edges later
		index_q.push_back(i);
		due_q.push_back(step + 2);
	endtask

	task automatic check_vector(input string name, input operand_fetch_pkg::vector_t actual,
		input operand_fetch_pkg::vector_t expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_scalar(input string name, input operand_fetch_pkg::scalar_t actual,
		input operand_fetch_pkg::scalar_t expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_mask(input string name, input operand_fetch_pkg::lane_mask_t actual,
		input operand_fetch_pkg::lane_mask_t expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_valid(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_thread(input string name, input operand_fetch_pkg::thread_idx_t actual,
		input operand_fetch_pkg::thread_idx_t expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_subcycle(input string name, input operand_fetch_pkg::subcycle_t actual,
		input operand_fetch_pkg::subcycle_t expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	// Idle and writeback cycles only need a clear valid at the output
	task automatic compare_result(input int i);
		int errors_before;
		string verdict;
		errors_before = errors;
		check_valid("of_instruction_valid", of_instruction_valid, rec_ev[i]);
		if (rec_kind[i] == "I")
		begin
			tests++;
			// Pass-through fields move on even for a squashed instruction
			check_thread("of_thread_idx", of_thread_idx, rec_thread[i]);
			check_subcycle("of_subcycle", of_subcycle, operand_fetch_pkg::subcycle_t'(i));
			check_scalar("of_pc", of_pc, rec_pc[i]);
			check_scalar("of_immediate_value", of_immediate_value, rec_imm[i]);
			if (rec_chk[i][0])
				check_vector("of_operand1", of_operand1, rec_op1_exp[i]);
			if (rec_chk[i][1])
				check_vector("of_operand2", of_operand2, rec_op2_exp[i]);
			if (rec_chk[i][2])
				check_mask("of_mask_value", of_mask_value, rec_mask_exp[i]);
			if (rec_chk[i][3])
				check_vector("of_store_value", of_store_value, rec_store_exp[i]);
			if (errors == errors_before)
				verdict = "ok";
			else
				verdict = "wrong";
			$display("Record %0d issue thread %0d valid %0d: %s", i, rec_thread[i],
				rec_ev[i], verdict);
		end
	endtask

	task automatic advance_cycle;
		@(posedge clk);
		#1;
		step++;
		while (due_q.size() > 0 && due_q[0] == step)
		begin
			compare_result(index_q[0]);
			void'(due_q.pop_front());
			void'(index_q.pop_front());
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		cycle_count = 0;
		cycle_limit = 1000;
		step = 0;
		errors = 0;
		tests = 0;
		drive_idle();
		load_cases(loaded);

		if (!loaded)
			$display("Simulation failed");
		else
		begin
			cycle_limit = 4 * num_records + 20;

			repeat (3) @(posedge clk);
			#1;
			reset = 1'b0;

			for (int i = 0; i < num_records; i++)
			begin
				apply_record(i);
				advance_cycle();
			end
			drive_idle();
			while (due_q.size() > 0)
				advance_cycle();

			$display("Tests run %0d, checks failed %0d", tests, errors);
			if (errors == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/operand_fetch_stage.sv
// Operand fetch stage of the multithreaded vector core, two cycles deep.
// The register files read during the first cycle, and operand_select
// registers the chosen operands at the second edge. One instruction can
// issue each cycle and there is never a stall.

`timescale 1ns/1ps
`default_nettype none

module operand_fetch_stage (
	input wire clk,
	input wire reset,

	// Issue fields from thread select
	input logic ts_instruction_valid,
	input operand_fetch_pkg::thread_idx_t ts_thread_idx,
	input operand_fetch_pkg::subcycle_t ts_subcycle,
	input logic ts_has_scalar1,
	input logic ts_has_scalar2,
	input logic ts_has_vector1,
	input logic ts_has_vector2,
	input operand_fetch_pkg::register_idx_t ts_scalar_sel1,
	input operand_fetch_pkg::register_idx_t ts_scalar_sel2,
	input operand_fetch_pkg::register_idx_t ts_vector_sel1,
	input operand_fetch_pkg::register_idx_t ts_vector_sel2,
	input operand_fetch_pkg::op1_src_t ts_op1_src,
	input operand_fetch_pkg::op2_src_t ts_op2_src,
	input operand_fetch_pkg::mask_src_t ts_mask_src,
	input logic ts_store_value_is_vector,
	input operand_fetch_pkg::scalar_t ts_pc,
	input operand_fetch_pkg::scalar_t ts_immediate_value,

	// Rollback strobe
	input logic wb_rollback_en,
	input operand_fetch_pkg::thread_idx_t wb_rollback_thread_idx,

	// Writeback into the register files
	input logic wb_writeback_en,
	input operand_fetch_pkg::thread_idx_t wb_writeback_thread_idx,
	input operand_fetch_pkg::register_idx_t wb_writeback_reg,
	input logic wb_writeback_is_vector,
	input operand_fetch_pkg::vector_t wb_writeback_value,
	input operand_fetch_pkg::lane_mask_t wb_writeback_mask,

	// To the execute stage
	output logic of_instruction_valid,
	output operand_fetch_pkg::thread_idx_t of_thread_idx,
	output operand_fetch_pkg::subcycle_t of_subcycle,
	output operand_fetch_pkg::vector_t of_operand1,
	output operand_fetch_pkg::vector_t of_operand2,
	output operand_fetch_pkg::lane_mask_t of_mask_value,
	output operand_fetch_pkg::vector_t of_store_value,
	output operand_fetch_pkg::scalar_t of_immediate_value,
	output operand_fetch_pkg::scalar_t of_pc
);

	// Register file results, one cycle after the issue
	operand_fetch_pkg::scalar_t scalar_val1;
	operand_fetch_pkg::scalar_t scalar_val2;
	operand_fetch_pkg::vector_t vector_val1;
	operand_fetch_pkg::vector_t vector_val2;

	// A scalar writeback takes lane 0 of the writeback value
	scalar_register_file scalar_rf_i (
		.clk(clk),
		.reset(reset),
		.instruction_valid(ts_instruction_valid),
		.thread_idx(ts_thread_idx),
		.has_scalar1(ts_has_scalar1),
		.has_scalar2(ts_has_scalar2),
		.scalar_sel1(ts_scalar_sel1),
		.scalar_sel2(ts_scalar_sel2),
		.writeback_en(wb_writeback_en),
		.writeback_is_vector(wb_writeback_is_vector),
		.writeback_thread_idx(wb_writeback_thread_idx),
		.writeback_reg(wb_writeback_reg),
		.writeback_value(wb_writeback_value[operand_fetch_pkg::SCALAR_WIDTH-1:0]),
		.scalar_val1(scalar_val1),
		.scalar_val2(scalar_val2)
	);

	vector_register_file vector_rf_i (
		.clk(clk),
		.thread_idx(ts_thread_idx),
		.has_vector1(ts_has_vector1),
		.has_vector2(ts_has_vector2),
		.vector_sel1(ts_vector_sel1),
		.vector_sel2(ts_vector_sel2),
		.writeback_en(wb_writeback_en),
		.writeback_is_vector(wb_writeback_is_vector),
		.writeback_thread_idx(wb_writeback_thread_idx),
		.writeback_reg(wb_writeback_reg),
		.writeback_value(wb_writeback_value),
		.writeback_mask(wb_writeback_mask),
		.vector_val1(vector_val1),
		.vector_val2(vector_val2)
	);

	operand_select operand_select_i (
		.clk(clk),
		.reset(reset),
		.ts_instruction_valid(ts_instruction_valid),
		.ts_thread_idx(ts_thread_idx),
		.ts_subcycle(ts_subcycle),
		.ts_op1_src(ts_op1_src),
		.ts_op2_src(ts_op2_src),
		.ts_mask_src(ts_mask_src),
		.ts_store_value_is_vector(ts_store_value_is_vector),
		.ts_pc(ts_pc),
		.ts_immediate_value(ts_immediate_value),
		.wb_rollback_en(wb_rollback_en),
		.wb_rollback_thread_idx(wb_rollback_thread_idx),
		.scalar_val1(scalar_val1),
		.scalar_val2(scalar_val2),
		.vector_val1(vector_val1),
		.vector_val2(vector_val2),
		.of_instruction_valid(of_instruction_valid),
		.of_thread_idx(of_thread_idx),
		.of_subcycle(of_subcycle),
		.of_operand1(of_operand1),
		.of_operand2(of_operand2),
		.of_mask_value(of_mask_value),
		.of_store_value(of_store_value),
		.of_immediate_value(of_immediate_value),
		.of_pc(of_pc)
	);

endmodule

`default_nettype wire

//--- verilog/operand_select.sv
// Pipeline control and operand selection for the operand fetch stage.
// Cycle 1 holds the instruction while the register files read, and cycle 2
// picks the operands, lane mask and store value from the read results.
// A rollback of a thread removes its instructions from both cycles.

`timescale 1ns/1ps
`default_nettype none

module operand_select (
	input wire clk,
	input wire reset,

	// Issue fields from thread select
	input logic ts_instruction_valid,
	input operand_fetch_pkg::thread_idx_t ts_thread_idx,
	input operand_fetch_pkg::subcycle_t ts_subcycle,
	input operand_fetch_pkg::op1_src_t ts_op1_src,
	input operand_fetch_pkg::op2_src_t ts_op2_src,
	input operand_fetch_pkg::mask_src_t ts_mask_src,
	input logic ts_store_value_is_vector,
	input operand_fetch_pkg::scalar_t ts_pc,
	input operand_fetch_pkg::scalar_t ts_immediate_value,

	// Rollback strobe
	input logic wb_rollback_en,
	input operand_fetch_pkg::thread_idx_t wb_rollback_thread_idx,

	// Register file read results, valid during cycle 2
	input operand_fetch_pkg::scalar_t scalar_val1,
	input operand_fetch_pkg::scalar_t scalar_val2,
	input operand_fetch_pkg::vector_t vector_val1,
	input operand_fetch_pkg::vector_t vector_val2,

	// To the execute stage
	output logic of_instruction_valid,
	output operand_fetch_pkg::thread_idx_t of_thread_idx,
	output operand_fetch_pkg::subcycle_t of_subcycle,
	output operand_fetch_pkg::vector_t of_operand1,
	output operand_fetch_pkg::vector_t of_operand2,
	output operand_fetch_pkg::lane_mask_t of_mask_value,
	output operand_fetch_pkg::vector_t of_store_value,
	output operand_fetch_pkg::scalar_t of_immediate_value,
	output operand_fetch_pkg::scalar_t of_pc
);

	logic cyc1_instruction_valid;
	operand_fetch_pkg::thread_idx_t cyc1_thread_idx;
	operand_fetch_pkg::subcycle_t cyc1_subcycle;
	operand_fetch_pkg::op1_src_t cyc1_op1_src;
	operand_fetch_pkg::op2_src_t cyc1_op2_src;
	operand_fetch_pkg::mask_src_t cyc1_mask_src;
	logic cyc1_store_value_is_vector;
	operand_fetch_pkg::scalar_t cyc1_pc;
	operand_fetch_pkg::scalar_t cyc1_adjusted_pc;
	operand_fetch_pkg::scalar_t cyc1_immediate_value;

	// Cycle 1 valid, dropped when this thread rolls back at the same edge
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			cyc1_instruction_valid <= 1'b0;
		else
			cyc1_instruction_valid <= ts_instruction_valid
				&& !(wb_rollback_en && wb_rollback_thread_idx == ts_thread_idx);
	end

	// Fields move on every cycle, even for a squashed instruction
	always_ff @(posedge clk)
	begin
		cyc1_thread_idx <= ts_thread_idx;
		cyc1_subcycle <= ts_subcycle;
		cyc1_op1_src <= ts_op1_src;
		cyc1_op2_src <= ts_op2_src;
		cyc1_mask_src <= ts_mask_src;
		cyc1_store_value_is_vector <= ts_store_value_is_vector;
		cyc1_pc <= ts_pc;
		cyc1_immediate_value <= ts_immediate_value;

		// A PC operand reads as the address of the next instruction
		cyc1_adjusted_pc <= ts_pc + 32'd4;
	end

	// Cycle 2 valid, with a second rollback check against the cycle 1 thread
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			of_instruction_valid <= 1'b0;
		else
			of_instruction_valid <= cyc1_instruction_valid
				&& !(wb_rollback_en && wb_rollback_thread_idx == cyc1_thread_idx);
	end

	// Operand choice, scalars are copied into every lane
	always_ff @(posedge clk)
	begin
		of_thread_idx <= cyc1_thread_idx;
		of_subcycle <= cyc1_subcycle;
		of_pc <= cyc1_pc;
		of_immediate_value <= cyc1_immediate_value;

		case (cyc1_op1_src)
			operand_fetch_pkg::OP1_SRC_VECTOR1:
				of_operand1 <= vector_val1;
			operand_fetch_pkg::OP1_SRC_PC:
				of_operand1 <= {operand_fetch_pkg::VECTOR_LANES{cyc1_adjusted_pc}};
			operand_fetch_pkg::OP1_SRC_SCALAR1:
				of_operand1 <= {operand_fetch_pkg::VECTOR_LANES{scalar_val1}};
			default:
				of_operand1 <= {operand_fetch_pkg::VECTOR_LANES{scalar_val1}};
		endcase

		case (cyc1_op2_src)
			operand_fetch_pkg::OP2_SRC_SCALAR2:
				of_operand2 <= {operand_fetch_pkg::VECTOR_LANES{scalar_val2}};
			operand_fetch_pkg::OP2_SRC_PC:
				of_operand2 <= {operand_fetch_pkg::VECTOR_LANES{cyc1_adjusted_pc}};
			operand_fetch_pkg::OP2_SRC_VECTOR2:
				of_operand2 <= vector_val2;
			operand_fetch_pkg::OP2_SRC_IMMEDIATE:
				of_operand2 <= {operand_fetch_pkg::VECTOR_LANES{cyc1_immediate_value}};
			default:
				of_operand2 <= {operand_fetch_pkg::VECTOR_LANES{cyc1_immediate_value}};
		endcase

		// A scalar register used as a mask supplies one bit per lane
		case (cyc1_mask_src)
			operand_fetch_pkg::MASK_SRC_SCALAR1:
				of_mask_value <= scalar_val1[operand_fetch_pkg::VECTOR_LANES-1:0];
			operand_fetch_pkg::MASK_SRC_SCALAR2:
				of_mask_value <= scalar_val2[operand_fetch_pkg::VECTOR_LANES-1:0];
			operand_fetch_pkg::MASK_SRC_ALL_ONES:
				of_mask_value <= {operand_fetch_pkg::VECTOR_LANES{1'b1}};
			default:
				of_mask_value <= {operand_fetch_pkg::VECTOR_LANES{1'b1}};
		endcase

		// Scalar stores put their value in lane 0 and clear the rest
		if (cyc1_store_value_is_vector)
			of_store_value <= vector_val2;
		else
			of_store_value <= {{(operand_fetch_pkg::VECTOR_LANES - 1)
				* operand_fetch_pkg::SCALAR_WIDTH{1'b0}}, scalar_val2};
	end

endmodule

`default_nettype wire

//--- verilog/vector_register_file.sv
// Vector registers of every hardware thread, stored as one memory per lane.
// A vector writeback updates only the lanes whose mask bit is set, so
// partial register updates leave the other lanes untouched.

`timescale 1ns/1ps
`default_nettype none

module vector_register_file (
	input wire clk,

	// Issue side
	input operand_fetch_pkg::thread_idx_t thread_idx,
	input logic has_vector1,
	input logic has_vector2,
	input operand_fetch_pkg::register_idx_t vector_sel1,
	input operand_fetch_pkg::register_idx_t vector_sel2,

	// Writeback side
	input logic writeback_en,
	input logic writeback_is_vector,
	input operand_fetch_pkg::thread_idx_t writeback_thread_idx,
	input operand_fetch_pkg::register_idx_t writeback_reg,
	input operand_fetch_pkg::vector_t writeback_value,
	input operand_fetch_pkg::lane_mask_t writeback_mask,

	// Read results, one cycle after the issue
	output operand_fetch_pkg::vector_t vector_val1,
	output operand_fetch_pkg::vector_t vector_val2
);

	logic [operand_fetch_pkg::REG_ADDR_WIDTH-1:0] read1_addr;
	logic [operand_fetch_pkg::REG_ADDR_WIDTH-1:0] read2_addr;
	logic [operand_fetch_pkg::REG_ADDR_WIDTH-1:0] write_addr;
	logic vector_write;

	// All lanes share the same thread-qualified addresses
	assign read1_addr = {thread_idx, vector_sel1};
	assign read2_addr = {thread_idx, vector_sel2};
	assign write_addr = {writeback_thread_idx, writeback_reg};

	// Scalar writebacks belong to the other file
	assign vector_write = writeback_en && writeback_is_vector;

	genvar lane;
	generate
		for (lane = 0; lane < operand_fetch_pkg::VECTOR_LANES; lane++)
		begin : lane_gen
			// One lane's slice of every vector register
			// Its write enable also needs that lane's mask bit
			sram_2r1w #(
				.DATA_WIDTH(operand_fetch_pkg::SCALAR_WIDTH),
				.SIZE(operand_fetch_pkg::NUM_REGISTERS * operand_fetch_pkg::THREADS_PER_CORE)
			) lane_regs_i (
				.clk(clk),
				.read1_en(has_vector1),
				.read1_addr(read1_addr),
				.read1_data(vector_val1[lane*operand_fetch_pkg::SCALAR_WIDTH +:
					operand_fetch_pkg::SCALAR_WIDTH]),
				.read2_en(has_vector2),
				.read2_addr(read2_addr),
				.read2_data(vector_val2[lane*operand_fetch_pkg::SCALAR_WIDTH +:
					operand_fetch_pkg::SCALAR_WIDTH]),
				.write_en(vector_write && writeback_mask[lane]),
				.write_addr(write_addr),
				.write_data(writeback_value[lane*operand_fetch_pkg::SCALAR_WIDTH +:
					operand_fetch_pkg::SCALAR_WIDTH])
			);
		end
	endgenerate

endmodule

`default_nettype wire

//--- verilog/scalar_register_file.sv
// Scalar registers of every hardware thread in one two-read memory.
// Reads are qualified by the issuing thread and by instruction valid, and
// their words come back one cycle after the issue.

`timescale 1ns/1ps
`default_nettype none

module scalar_register_file (
	input wire clk,
	input wire reset,

	// Issue side
	input logic instruction_valid,
	input operand_fetch_pkg::thread_idx_t thread_idx,
	input logic has_scalar1,
	input logic has_scalar2,
	input operand_fetch_pkg::register_idx_t scalar_sel1,
	input operand_fetch_pkg::register_idx_t scalar_sel2,

	// Writeback side
	input logic writeback_en,
	input logic writeback_is_vector,
	input operand_fetch_pkg::thread_idx_t writeback_thread_idx,
	input operand_fetch_pkg::register_idx_t writeback_reg,
	input operand_fetch_pkg::scalar_t writeback_value,

	// Read results, one cycle after the issue
	output operand_fetch_pkg::scalar_t scalar_val1,
	output operand_fetch_pkg::scalar_t scalar_val2
);

	logic [operand_fetch_pkg::REG_ADDR_WIDTH-1:0] read1_addr;
	logic [operand_fetch_pkg::REG_ADDR_WIDTH-1:0] read2_addr;
	logic [operand_fetch_pkg::REG_ADDR_WIDTH-1:0] write_addr;
	logic read1_en;
	logic read2_en;
	logic write_en;

	// Each thread owns its own block of registers
	assign read1_addr = {thread_idx, scalar_sel1};
	assign read2_addr = {thread_idx, scalar_sel2};
	assign write_addr = {writeback_thread_idx, writeback_reg};

	// Ports only fetch for a real instruction that names the register
	assign read1_en = instruction_valid && has_scalar1;
	assign read2_en = instruction_valid && has_scalar2;

	// Vector writebacks go to the vector file, and nothing is written in reset
	assign write_en = writeback_en && !writeback_is_vector && !reset;

	sram_2r1w #(
		.DATA_WIDTH(operand_fetch_pkg::SCALAR_WIDTH),
		.SIZE(operand_fetch_pkg::NUM_REGISTERS * operand_fetch_pkg::THREADS_PER_CORE)
	) scalar_regs_i (
		.clk(clk),
		.read1_en(read1_en),
		.read1_addr(read1_addr),
		.read1_data(scalar_val1),
		.read2_en(read2_en),
		.read2_addr(read2_addr),
		.read2_data(scalar_val2),
		.write_en(write_en),
		.write_addr(write_addr),
		.write_data(writeback_value)
	);

endmodule

`default_nettype wire

//--- verilog/sram_2r1w.sv
// Register memory with two registered read ports and one write port.
// Both register files build on it, the scalar file with one instance and
// the vector file with one instance per lane.

`timescale 1ns/1ps
`default_nettype none

module sram_2r1w #(
	parameter int DATA_WIDTH = 32,
	parameter int SIZE = 128
) (
	input wire clk,

	// Read port 1
	input logic read1_en,
	input logic [$clog2(SIZE)-1:0] read1_addr,
	output logic [DATA_WIDTH-1:0] read1_data,

	// Read port 2
	input logic read2_en,
	input logic [$clog2(SIZE)-1:0] read2_addr,
	output logic [DATA_WIDTH-1:0] read2_data,

	// Write port
	input logic write_en,
	input logic [$clog2(SIZE)-1:0] write_addr,
	input logic [DATA_WIDTH-1:0] write_data
);

	// The storage array itself, with no reset
	logic [DATA_WIDTH-1:0] data[SIZE];

	// A write lands at the edge, so reads from the next cycle see it
	always_ff @(posedge clk)
	begin
		if (write_en)
			data[write_addr] <= write_data;
	end

	// A disabled read port keeps its last word
	// Reading a word in the same cycle it is written gives an undefined result
	always_ff @(posedge clk)
	begin
		if (read1_en)
			read1_data <= data[read1_addr];

		if (read2_en)
			read2_data <= data[read2_addr];
	end

endmodule

`default_nettype wire

//--- verilog/operand_fetch_pkg.sv
// Shared widths, counts, data types and operand selector codes for the
// operand fetch stage. Every design file refers to these by scoped name.
// Selector codes are plain vector constants decoded at the second cycle.

`default_nettype none

package operand_fetch_pkg;

	// Core geometry
	localparam int VECTOR_LANES = 4;
	localparam int THREADS_PER_CORE = 4;
	localparam int NUM_REGISTERS = 32;
	localparam int SCALAR_WIDTH = 32;

	// Register memory address is the thread index above the register index
	localparam int REG_ADDR_WIDTH = $clog2(THREADS_PER_CORE) + $clog2(NUM_REGISTERS);

	typedef logic [SCALAR_WIDTH-1:0] scalar_t;

	// Lane 0 sits in the low bits, lane 3 in the high bits
	typedef logic [VECTOR_LANES*SCALAR_WIDTH-1:0] vector_t;

	typedef logic [VECTOR_LANES-1:0] lane_mask_t;
	typedef logic [$clog2(THREADS_PER_CORE)-1:0] thread_idx_t;
	typedef logic [$clog2(NUM_REGISTERS)-1:0] register_idx_t;

	// Carried along with the instruction and never interpreted here
	typedef logic [3:0] subcycle_t;

	// Source of operand 1
	typedef logic [1:0] op1_src_t;
	localparam op1_src_t OP1_SRC_SCALAR1 = 2'd0;
	localparam op1_src_t OP1_SRC_VECTOR1 = 2'd1;
	localparam op1_src_t OP1_SRC_PC = 2'd2;

	// Source of operand 2
	typedef logic [1:0] op2_src_t;
	localparam op2_src_t OP2_SRC_SCALAR2 = 2'd0;
	localparam op2_src_t OP2_SRC_VECTOR2 = 2'd1;
	localparam op2_src_t OP2_SRC_PC = 2'd2;
	localparam op2_src_t OP2_SRC_IMMEDIATE = 2'd3;

	// Source of the lane mask
	typedef logic [1:0] mask_src_t;
	localparam mask_src_t MASK_SRC_SCALAR1 = 2'd0;
	localparam mask_src_t MASK_SRC_SCALAR2 = 2'd1;
	localparam mask_src_t MASK_SRC_ALL_ONES = 2'd2;

endpackage

`default_nettype wire
